// File: hdl/trace_cfg_pkg.sv
/*
 * Sizing constants for the trace capture buffer.
 * Covers the storage depth, the fill limit used for write back-pressure,
 * the reader return buffer, the flush settle time and the register map.
 * Every module refers to these through trace_cfg_pkg:: scoped names.
 */
`default_nettype none

package trace_cfg_pkg;

   // trace word and external storage
   localparam int data_width      = 64;
   localparam int buf_depth       = 64;
   localparam int buf_addr_width  = $clog2(buf_depth);
   localparam int fill_width      = buf_addr_width + 1;

   // writes are refused at or above this occupancy
   localparam int fill_limit      = buf_depth - 4;

   // reader return buffer
   localparam int rd_fifo_depth       = 8;
   localparam int rd_fifo_addr_width  = $clog2(rd_fifo_depth);

   // settle cycles at the start of each flush state
   localparam int flush_delay     = 7;
   localparam int flush_cnt_width = $clog2(flush_delay + 1);

   // register map
   localparam int csr_addr_width  = 4;
   localparam int csr_data_width  = 32;
   localparam logic [csr_addr_width-1:0] csr_addr_ctrl   = 4'd0;
   localparam logic [csr_addr_width-1:0] csr_addr_status = 4'd1;
   localparam logic [csr_addr_width-1:0] csr_addr_fill   = 4'd2;
   localparam logic [csr_addr_width-1:0] csr_addr_count  = 4'd3;
   localparam int count_width     = 32;

endpackage

`default_nettype wire

// File: hdl/trace_bus_pkg.sv
/*
 * Bus and state types shared between the trace capture blocks.
 * Holds the stored beat layout, the internal write and read request
 * records, the storage command, the register request and the
 * sequencer state encoding.
 */
`default_nettype none

package trace_bus_pkg;

   // one storage word, also the stream beat on both trace and dbg sides
   typedef struct packed {
      logic                                sop;
      logic                                eop;
      logic [trace_cfg_pkg::data_width-1:0] data;
   } stored_beat_t;

   // writer to arbiter
   typedef struct packed {
      logic [trace_cfg_pkg::buf_addr_width-1:0] addr;
      stored_beat_t                             beat;
   } wr_req_t;

   // reader to arbiter, address only
   typedef struct packed {
      logic [trace_cfg_pkg::buf_addr_width-1:0] addr;
   } rd_req_t;

   // registered storage master command
   typedef struct packed {
      logic                                     write;
      logic                                     read;
      logic [trace_cfg_pkg::buf_addr_width-1:0] addr;
      stored_beat_t                             wdata;
   } mem_cmd_t;

   // simple register port request
   typedef struct packed {
      logic                                     write;
      logic                                     read;
      logic [trace_cfg_pkg::csr_addr_width-1:0] addr;
      logic [trace_cfg_pkg::csr_data_width-1:0] wdata;
   } csr_req_t;

   // capture sequencer state, also reported in the status register
   typedef enum logic [1:0] {
      capt_idle     = 2'd0,
      capt_fifo     = 2'd1,
      capt_wr_flush = 2'd2,
      capt_rd_flush = 2'd3
   } capt_state_t;

endpackage

`default_nettype wire

// File: hdl/trace_buf_writer.sv
/*
 * Write side of the trace buffer.
 * Accepts beats from the trace stream into a one-entry holding register
 * and presents each one as a storage write request at a wrapping write
 * pointer. The request stays up until the arbiter takes it.
 */
`default_nettype none

module trace_buf_writer (
   input  wire logic                         clk,
   input  wire logic                         arst_n,
   input  wire logic                         wr_en,
   input  wire logic                         trace_valid,
   input  wire trace_bus_pkg::stored_beat_t  trace_beat,
   input  wire logic                         wr_req_ready,
   output logic                              trace_ready,
   output logic                              wr_req_valid,
   output trace_bus_pkg::wr_req_t            wr_req,
   output logic                              wr_idle
);

   logic                                     hold_valid;
   trace_bus_pkg::stored_beat_t              hold_beat;
   logic [trace_cfg_pkg::buf_addr_width-1:0] wr_ptr;
   logic                                     accept;
   logic                                     drain;

   // take a new beat when the holding slot is free or emptying this cycle
   assign trace_ready = wr_en & (~hold_valid | wr_req_ready);
   assign accept      = trace_valid & trace_ready;
   assign drain       = hold_valid & wr_req_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hold_valid <= 1'b0;
      end else if (accept) begin
         hold_valid <= 1'b1;
      end else if (drain) begin
         hold_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         hold_beat <= trace_beat;
      end
   end

   // pointer parks at zero while disabled and drained, so a new capture
   // starts at word 0 together with the reader
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
      end else if (!wr_en && !hold_valid) begin
         wr_ptr <= '0;
      end else if (drain) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   assign wr_req_valid = hold_valid;
   assign wr_req.addr  = wr_ptr;
   assign wr_req.beat  = hold_beat;
   assign wr_idle      = ~hold_valid;

endmodule

`default_nettype wire

// File: hdl/trace_buf_reader.sv
/*
 * Read side of the trace buffer.
 * Issues storage reads in address order while stored words are available,
 * collects the returned words in a small buffer and drives them out on the
 * debug stream. Reads stop while the buffer plus the reads in flight would
 * overflow it, so dbg back-pressure stalls the storage reads.
 */
`default_nettype none

module trace_buf_reader (
   input  wire logic                                 clk,
   input  wire logic                                 arst_n,
   input  wire logic                                 rd_en,
   input  wire logic [trace_cfg_pkg::fill_width-1:0] fill,
   input  wire logic                                 rd_req_ready,
   input  wire logic                                 mem_readdatavalid,
   input  wire trace_bus_pkg::stored_beat_t          mem_readdata,
   input  wire logic                                 dbg_ready,
   output logic                                      rd_req_valid,
   output trace_bus_pkg::rd_req_t                    rd_req,
   output logic                                      dbg_valid,
   output trace_bus_pkg::stored_beat_t               dbg_beat,
   output logic                                      rd_idle
);

   localparam int aw = trace_cfg_pkg::rd_fifo_addr_width;

   trace_bus_pkg::stored_beat_t              ret_mem [trace_cfg_pkg::rd_fifo_depth];
   logic [aw-1:0]                            ret_wr_idx;
   logic [aw-1:0]                            ret_rd_idx;
   logic [aw:0]                              ret_count;
   logic [aw:0]                              outstanding;
   logic [aw:0]                              in_use;
   logic [trace_cfg_pkg::fill_width-1:0]     outstanding_ext;
   logic [trace_cfg_pkg::buf_addr_width-1:0] rd_ptr;
   logic                                     rd_grant;
   logic                                     pop;

   assign in_use          = outstanding + ret_count;
   assign outstanding_ext = {{(trace_cfg_pkg::fill_width - aw - 1){1'b0}}, outstanding};

   // fill only drops once a read completes, so a granted read still
   // counts in fill; requiring fill above the reads in flight keeps the
   // reader behind the written data
   assign rd_req_valid = rd_en && (fill > outstanding_ext)
                         && (in_use < trace_cfg_pkg::rd_fifo_depth);
   assign rd_req.addr  = rd_ptr;
   assign rd_grant     = rd_req_valid & rd_req_ready;

   assign dbg_valid = (ret_count != '0);
   assign dbg_beat  = ret_mem[ret_rd_idx];
   assign pop       = dbg_valid & dbg_ready;
   assign rd_idle   = (outstanding == '0) && (ret_count == '0);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_ptr      <= '0;
         outstanding <= '0;
      end else begin
         if (!rd_en) begin
            rd_ptr <= '0;
         end else if (rd_grant) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({rd_grant, mem_readdatavalid})
            2'b10:   outstanding <= outstanding + 1'b1;
            2'b01:   outstanding <= outstanding - 1'b1;
            default: outstanding <= outstanding;
         endcase
      end
   end

   // return buffer control
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ret_wr_idx <= '0;
         ret_rd_idx <= '0;
         ret_count  <= '0;
      end else begin
         if (mem_readdatavalid) begin
            ret_wr_idx <= ret_wr_idx + 1'b1;
         end
         if (pop) begin
            ret_rd_idx <= ret_rd_idx + 1'b1;
         end
         case ({mem_readdatavalid, pop})
            2'b10:   ret_count <= ret_count + 1'b1;
            2'b01:   ret_count <= ret_count - 1'b1;
            default: ret_count <= ret_count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (mem_readdatavalid) begin
         ret_mem[ret_wr_idx] <= mem_readdata;
      end
   end

endmodule

`default_nettype wire

// File: hdl/storage_arbiter.sv
/*
 * Storage arbiter and fill-level counter.
 * Merges reader and writer requests into one registered storage command,
 * with reads taking priority. Writes are held off once the fill level
 * reaches the limit. The fill level counts completed writes minus
 * completed reads and clears on start.
 */
`default_nettype none

module storage_arbiter (
   input  wire logic                    clk,
   input  wire logic                    arst_n,
   input  wire logic                    start,
   input  wire logic                    wr_req_valid,
   input  wire trace_bus_pkg::wr_req_t  wr_req,
   input  wire logic                    rd_req_valid,
   input  wire trace_bus_pkg::rd_req_t  rd_req,
   input  wire logic                    mem_waitrequest,
   output logic                         wr_req_ready,
   output logic                         rd_req_ready,
   output trace_bus_pkg::mem_cmd_t      mem_cmd,
   output logic [trace_cfg_pkg::fill_width-1:0] fill
);

   logic                                     cmd_write;
   logic                                     cmd_read;
   logic [trace_cfg_pkg::buf_addr_width-1:0] cmd_addr;
   trace_bus_pkg::stored_beat_t              cmd_wdata;
   logic                                     slot_free;
   logic                                     near_full;
   logic                                     rd_grant;
   logic                                     wr_grant;

   // a new command may be loaded when none is pending or the pending one
   // completes this cycle
   assign slot_free = ~(cmd_write | cmd_read) | ~mem_waitrequest;
   assign near_full = (fill >= trace_cfg_pkg::fill_limit);

   assign rd_req_ready = slot_free;
   assign wr_req_ready = slot_free & ~rd_req_valid & ~near_full;
   assign rd_grant     = rd_req_valid & rd_req_ready;
   assign wr_grant     = wr_req_valid & wr_req_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cmd_write <= 1'b0;
         cmd_read  <= 1'b0;
      end else if (slot_free) begin
         cmd_read  <= rd_grant;
         cmd_write <= wr_grant;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_grant) begin
         cmd_addr <= rd_req.addr;
      end else if (wr_grant) begin
         cmd_addr  <= wr_req.addr;
         cmd_wdata <= wr_req.beat;
      end
   end

   always_comb begin
      mem_cmd.write = cmd_write;
      mem_cmd.read  = cmd_read;
      mem_cmd.addr  = cmd_addr;
      mem_cmd.wdata = cmd_wdata;
   end

   // only one command completes per cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fill <= '0;
      end else if (start) begin
         fill <= '0;
      end else if (cmd_write && !mem_waitrequest) begin
         fill <= fill + 1'b1;
      end else if (cmd_read && !mem_waitrequest) begin
         fill <= fill - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: hdl/capture_sequencer.sv
/*
 * Capture sequencer.
 * Moves from idle to FIFO capture on start, then on stop flushes the
 * write path and the read path in turn before returning to idle.
 * Each flush waits a fixed settle time before it checks for completion.
 */
`default_nettype none

module capture_sequencer (
   input  wire logic                                 clk,
   input  wire logic                                 arst_n,
   input  wire logic                                 start,
   input  wire logic                                 stop,
   input  wire logic                                 wr_idle,
   input  wire logic                                 rd_idle,
   input  wire logic [trace_cfg_pkg::fill_width-1:0] fill,
   output logic                                      wr_en,
   output logic                                      rd_en,
   output trace_bus_pkg::capt_state_t                state
);

   localparam logic [trace_cfg_pkg::flush_cnt_width-1:0] delay_init =
      trace_cfg_pkg::flush_delay[trace_cfg_pkg::flush_cnt_width-1:0];

   logic [trace_cfg_pkg::flush_cnt_width-1:0] delay_cnt;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= trace_bus_pkg::capt_idle;
         wr_en     <= 1'b0;
         rd_en     <= 1'b0;
         delay_cnt <= '0;
      end else begin
         if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
         end
         case (state)
            trace_bus_pkg::capt_fifo: begin
               if (stop) begin
                  state     <= trace_bus_pkg::capt_wr_flush;
                  wr_en     <= 1'b0;
                  delay_cnt <= delay_init;
               end
            end
            // reader keeps draining while the writer empties
            trace_bus_pkg::capt_wr_flush: begin
               if (delay_cnt == '0 && wr_idle) begin
                  state     <= trace_bus_pkg::capt_rd_flush;
                  delay_cnt <= delay_init;
               end
            end
            trace_bus_pkg::capt_rd_flush: begin
               if (delay_cnt == '0 && fill == '0 && rd_idle) begin
                  state <= trace_bus_pkg::capt_idle;
                  rd_en <= 1'b0;
               end
            end
            default: begin
               if (start) begin
                  state <= trace_bus_pkg::capt_fifo;
                  wr_en <= 1'b1;
                  rd_en <= 1'b1;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/capture_csr.sv
/*
 * Management registers for the trace capture buffer.
 * A control write pulses start (bit 0) or stop (bit 1) on the next cycle.
 * Reads return the sequencer state, the storage fill level or the number
 * of beats accepted since the last start, one cycle after the request.
 */
`default_nettype none

module capture_csr (
   input  wire logic                                     clk,
   input  wire logic                                     arst_n,
   input  wire trace_bus_pkg::csr_req_t                  csr_req,
   input  wire trace_bus_pkg::capt_state_t               state,
   input  wire logic [trace_cfg_pkg::fill_width-1:0]     fill,
   input  wire logic                                     trace_valid,
   input  wire logic                                     trace_ready,
   output logic [trace_cfg_pkg::csr_data_width-1:0]      csr_readdata,
   output logic                                          start,
   output logic                                          stop
);

   localparam int dw = trace_cfg_pkg::csr_data_width;

   logic [trace_cfg_pkg::count_width-1:0] beat_count;
   logic                                  ctrl_wr;

   assign ctrl_wr = csr_req.write && (csr_req.addr == trace_cfg_pkg::csr_addr_ctrl);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         start <= 1'b0;
         stop  <= 1'b0;
      end else begin
         start <= ctrl_wr & csr_req.wdata[0];
         stop  <= ctrl_wr & csr_req.wdata[1];
      end
   end

   // beats accepted on the trace input since the last start
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         beat_count <= '0;
      end else if (start) begin
         beat_count <= '0;
      end else if (trace_valid && trace_ready) begin
         beat_count <= beat_count + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         csr_readdata <= '0;
      end else if (csr_req.read) begin
         case (csr_req.addr)
            trace_cfg_pkg::csr_addr_status:
               csr_readdata <= {{(dw - 2){1'b0}}, state};
            trace_cfg_pkg::csr_addr_fill:
               csr_readdata <= {{(dw - trace_cfg_pkg::fill_width){1'b0}}, fill};
            trace_cfg_pkg::csr_addr_count:
               csr_readdata <= beat_count;
            default:
               csr_readdata <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/trace_capture_top.sv
/*
 * Trace capture buffer top level, FIFO mode.
 * Trace beats are written in order to external storage and read back in
 * order onto the debug stream. Connects writer, reader, storage arbiter,
 * sequencer and register block.
 */
`default_nettype none

module trace_capture_top (
   input  wire logic                                 clk,
   input  wire logic                                 arst_n,
   input  wire logic                                 trace_valid,
   output logic                                      trace_ready,
   input  wire trace_bus_pkg::stored_beat_t          trace_beat,
   output logic                                      dbg_valid,
   input  wire logic                                 dbg_ready,
   output trace_bus_pkg::stored_beat_t               dbg_beat,
   output trace_bus_pkg::mem_cmd_t                   mem_cmd,
   input  wire logic                                 mem_waitrequest,
   input  wire logic                                 mem_readdatavalid,
   input  wire trace_bus_pkg::stored_beat_t          mem_readdata,
   input  wire trace_bus_pkg::csr_req_t              csr_req,
   output logic [trace_cfg_pkg::csr_data_width-1:0]  csr_readdata
);

   logic                                 start;
   logic                                 stop;
   logic                                 wr_en;
   logic                                 rd_en;
   logic                                 wr_idle;
   logic                                 rd_idle;
   logic [trace_cfg_pkg::fill_width-1:0] fill;
   trace_bus_pkg::capt_state_t           state;
   logic                                 wr_req_valid;
   logic                                 wr_req_ready;
   trace_bus_pkg::wr_req_t               wr_req;
   logic                                 rd_req_valid;
   logic                                 rd_req_ready;
   trace_bus_pkg::rd_req_t               rd_req;

   trace_buf_writer u_writer (
      .clk          (clk),
      .arst_n       (arst_n),
      .wr_en        (wr_en),
      .trace_valid  (trace_valid),
      .trace_beat   (trace_beat),
      .wr_req_ready (wr_req_ready),
      .trace_ready  (trace_ready),
      .wr_req_valid (wr_req_valid),
      .wr_req       (wr_req),
      .wr_idle      (wr_idle)
   );

   trace_buf_reader u_reader (
      .clk               (clk),
      .arst_n            (arst_n),
      .rd_en             (rd_en),
      .fill              (fill),
      .rd_req_ready      (rd_req_ready),
      .mem_readdatavalid (mem_readdatavalid),
      .mem_readdata      (mem_readdata),
      .dbg_ready         (dbg_ready),
      .rd_req_valid      (rd_req_valid),
      .rd_req            (rd_req),
      .dbg_valid         (dbg_valid),
      .dbg_beat          (dbg_beat),
      .rd_idle           (rd_idle)
   );

   storage_arbiter u_arbiter (
      .clk             (clk),
      .arst_n          (arst_n),
      .start           (start),
      .wr_req_valid    (wr_req_valid),
      .wr_req          (wr_req),
      .rd_req_valid    (rd_req_valid),
      .rd_req          (rd_req),
      .mem_waitrequest (mem_waitrequest),
      .wr_req_ready    (wr_req_ready),
      .rd_req_ready    (rd_req_ready),
      .mem_cmd         (mem_cmd),
      .fill            (fill)
   );

   capture_sequencer u_sequencer (
      .clk     (clk),
      .arst_n  (arst_n),
      .start   (start),
      .stop    (stop),
      .wr_idle (wr_idle),
      .rd_idle (rd_idle),
      .fill    (fill),
      .wr_en   (wr_en),
      .rd_en   (rd_en),
      .state   (state)
   );

   capture_csr u_csr (
      .clk          (clk),
      .arst_n       (arst_n),
      .csr_req      (csr_req),
      .state        (state),
      .fill         (fill),
      .trace_valid  (trace_valid),
      .trace_ready  (trace_ready),
      .csr_readdata (csr_readdata),
      .start        (start),
      .stop         (stop)
   );

endmodule

`default_nettype wire

// File: dv/storage_model.sv
/*
 * Behavioral external storage for the trace capture testbench.
 * Answers the DUT storage master with a random waitrequest and returns
 * read data two cycles after each completed read, pipelined, in issue
 * order. Outputs change on the falling clock edge.
 */
`default_nettype none

module storage_model (
   input  wire logic                        clk,
   input  wire logic                        arst_n,
   input  wire trace_bus_pkg::mem_cmd_t     mem_cmd,
   output logic                             mem_waitrequest,
   output logic                             mem_readdatavalid,
   output trace_bus_pkg::stored_beat_t      mem_readdata
);
   timeunit 1ns;
   timeprecision 100ps;

   trace_bus_pkg::stored_beat_t mem [trace_cfg_pkg::buf_depth];
   trace_bus_pkg::stored_beat_t rd_pipe_data [2];
   logic [1:0]                  rd_pipe_valid = 2'b00;
   logic                        wait_q        = 1'b0;
   logic                        rvalid_q      = 1'b0;
   trace_bus_pkg::stored_beat_t rdata_q       = '0;
   integer                      seed          = 7;

   assign mem_waitrequest   = wait_q;
   assign mem_readdatavalid = rvalid_q;
   assign mem_readdata      = rdata_q;

   // commands complete on an edge with waitrequest low
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_pipe_valid <= 2'b00;
      end else begin
         if (mem_cmd.write && !wait_q) begin
            mem[mem_cmd.addr] <= mem_cmd.wdata;
         end
         rd_pipe_valid   <= {rd_pipe_valid[0], mem_cmd.read && !wait_q};
         rd_pipe_data[0] <= mem[mem_cmd.addr];
         rd_pipe_data[1] <= rd_pipe_data[0];
      end
   end

   // about one cycle in four is a wait cycle
   always @(negedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wait_q   <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         wait_q   <= (($random(seed) & 3) == 0);
         rvalid_q <= rd_pipe_valid[1];
         rdata_q  <= rd_pipe_data[1];
      end
   end

endmodule

`default_nettype wire

// File: dv/tb_trace_capture.sv
/*
 * Testbench for the trace capture buffer in FIFO mode.
 * Random packets go in on the trace stream while dbg_ready and the storage
 * waitrequest toggle at random. Every accepted beat is queued and the
 * assertions compare each dbg transfer with the head of that queue.
 * One phase holds dbg_ready low until the trace input stalls.
 */
`default_nettype none

module tb_trace_capture;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int main_beats   = 300;
   localparam int stall_beats  = 120;
   localparam int tail_beats   = 24;
   localparam int total_beats  = main_beats + stall_beats + tail_beats;
   // a beat costs one write and one read plus random waits and gaps
   localparam int beat_cycles  = 8;
   localparam int reset_cycles = 16;
   localparam int flush_cycles = 2 * (2 * trace_cfg_pkg::flush_delay + 40);
   localparam int timeout_cycles =
      4 * total_beats * beat_cycles + reset_cycles + flush_cycles;

   logic                                     clk;
   logic                                     arst_n      = 1'b0;
   logic                                     trace_valid = 1'b0;
   logic                                     trace_ready;
   trace_bus_pkg::stored_beat_t              trace_beat  = '0;
   logic                                     dbg_valid;
   logic                                     dbg_ready   = 1'b0;
   trace_bus_pkg::stored_beat_t              dbg_beat;
   trace_bus_pkg::mem_cmd_t                  mem_cmd;
   logic                                     mem_waitrequest;
   logic                                     mem_readdatavalid;
   trace_bus_pkg::stored_beat_t              mem_readdata;
   trace_bus_pkg::csr_req_t                  csr_req     = '0;
   logic [trace_cfg_pkg::csr_data_width-1:0] csr_readdata;

   // reference queue and stimulus bookkeeping
   trace_bus_pkg::stored_beat_t exp_q[$];
   trace_bus_pkg::stored_beat_t exp_head    = '0;
   int                          exp_pending = 0;
   int                          n_accepted  = 0;
   int                          n_checked   = 0;
   int                          errors      = 0;
   int                          cycle_count = 0;
   int                          stall_run   = 0;
   int                          beats_req   = 0;
   int                          beats_sent  = 0;
   logic                        beat_taken  = 1'b0;
   logic                        dbg_hold    = 1'b0;
   logic                        expect_idle = 1'b1;
   logic                        next_sop    = 1'b1;
   logic                        eop_pick;
   integer                      seed        = 7;

   trace_capture_top u_trace_capture_top (
      .clk               (clk),
      .arst_n            (arst_n),
      .trace_valid       (trace_valid),
      .trace_ready       (trace_ready),
      .trace_beat        (trace_beat),
      .dbg_valid         (dbg_valid),
      .dbg_ready         (dbg_ready),
      .dbg_beat          (dbg_beat),
      .mem_cmd           (mem_cmd),
      .mem_waitrequest   (mem_waitrequest),
      .mem_readdatavalid (mem_readdatavalid),
      .mem_readdata      (mem_readdata),
      .csr_req           (csr_req),
      .csr_readdata      (csr_readdata)
   );

   storage_model u_storage_model (
      .clk               (clk),
      .arst_n            (arst_n),
      .mem_cmd           (mem_cmd),
      .mem_waitrequest   (mem_waitrequest),
      .mem_readdatavalid (mem_readdatavalid),
      .mem_readdata      (mem_readdata)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic log_mismatch(input string msg);
      errors++;
      $display("FAIL %0t ns: %s", $time, msg);
   endtask

   task automatic note_failure(input string msg);
      errors++;
      $display("error at %0t ns: %s", $time, msg);
   endtask

   // nothing may move while the capture is idle
   idle_quiet: assert property (@(posedge clk) disable iff (!arst_n)
      expect_idle |-> (!trace_ready && !dbg_valid && !mem_cmd.write && !mem_cmd.read))
      else note_failure("trace_ready, dbg_valid or a storage strobe is high while idle");

   dbg_known: assert property (@(posedge clk) disable iff (!arst_n)
      (dbg_valid && dbg_ready) |-> (exp_pending != 0))
      else note_failure("dbg delivered a beat that was never accepted on the trace input");

   dbg_order: assert property (@(posedge clk) disable iff (!arst_n)
      (dbg_valid && dbg_ready && exp_pending != 0) |-> (dbg_beat == exp_head))
      else log_mismatch("dbg beat differs from the next accepted trace beat");

   dbg_steady: assert property (@(posedge clk) disable iff (!arst_n)
      (dbg_valid && !dbg_ready) |=> (dbg_valid && $stable(dbg_beat)))
      else log_mismatch("dbg beat changed or dropped before it was accepted");

   // reference queue follows both streams
   always @(posedge clk) begin
      if (arst_n) begin
         if (dbg_valid && dbg_ready && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            n_checked <= n_checked + 1;
         end
         if (trace_valid && trace_ready) begin
            exp_q.push_back(trace_beat);
            n_accepted <= n_accepted + 1;
         end
         exp_pending <= exp_q.size();
         exp_head    <= (exp_q.size() != 0) ? exp_q[0] : '0;
      end
      beat_taken <= trace_valid && trace_ready;
      stall_run  <= (trace_valid && !trace_ready) ? stall_run + 1 : 0;
   end

   // stimulus changes on the falling edge only
   always @(negedge clk) begin
      dbg_ready <= !dbg_hold && (($random(seed) & 3) != 0);
      if (trace_valid && !beat_taken) begin
         trace_valid <= 1'b1;
      end else if (beats_sent < beats_req && (($random(seed) & 3) != 0)) begin
         eop_pick        = (($random(seed) & 7) == 0);
         trace_valid     <= 1'b1;
         trace_beat.sop  <= next_sop;
         trace_beat.eop  <= eop_pick;
         trace_beat.data <= {$random(seed), $random(seed)};
         next_sop        = eop_pick;
         beats_sent      <= beats_sent + 1;
      end else begin
         trace_valid <= 1'b0;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("run stopped: the test did not finish within %0d cycles", timeout_cycles);
         $display("Test failed");
         $finish;
      end
   end

   task automatic write_register(input logic [trace_cfg_pkg::csr_addr_width-1:0] addr,
                                 input logic [31:0] data);
      @(negedge clk);
      csr_req.write = 1'b1;
      csr_req.addr  = addr;
      csr_req.wdata = data;
      @(negedge clk);
      csr_req = '0;
   endtask

   // read data is registered on the edge after the request
   task automatic read_register(input logic [trace_cfg_pkg::csr_addr_width-1:0] addr,
                                output logic [31:0] data);
      @(negedge clk);
      csr_req.read = 1'b1;
      csr_req.addr = addr;
      @(negedge clk);
      csr_req.read = 1'b0;
      data = csr_readdata;
   endtask

   task automatic run_capture(input int n_beats, input bit with_stall);
      logic [31:0] rd_data;
      logic [31:0] expected;
      expected    = with_stall ? n_beats + stall_beats : n_beats;
      expect_idle = 1'b0;
      write_register(trace_cfg_pkg::csr_addr_ctrl, 32'h1);
      beats_req = beats_req + n_beats;
      read_register(trace_cfg_pkg::csr_addr_status, rd_data);
      assert (rd_data == 32'(trace_bus_pkg::capt_fifo))
         else log_mismatch($sformatf("status %0d after start, expected fifo", rd_data));
      wait (beats_sent == beats_req && !trace_valid);
      if (with_stall) begin
         // with dbg blocked the storage fills up and the trace input must stall
         dbg_hold  = 1'b1;
         beats_req = beats_req + stall_beats;
         wait (stall_run >= 32);
         read_register(trace_cfg_pkg::csr_addr_fill, rd_data);
         assert (rd_data >= 32'(trace_cfg_pkg::fill_limit)
                 && rd_data <= 32'(trace_cfg_pkg::buf_depth))
            else log_mismatch($sformatf("fill %0d out of range while stalled", rd_data));
         dbg_hold = 1'b0;
         wait (beats_sent == beats_req && !trace_valid);
      end
      write_register(trace_cfg_pkg::csr_addr_ctrl, 32'h2);
      do begin
         read_register(trace_cfg_pkg::csr_addr_status, rd_data);
      end while (rd_data != 32'(trace_bus_pkg::capt_idle));
      expect_idle = 1'b1;
      read_register(trace_cfg_pkg::csr_addr_fill, rd_data);
      assert (rd_data == 32'd0)
         else log_mismatch($sformatf("fill %0d after the flush, expected 0", rd_data));
      assert (exp_pending == 0)
         else note_failure($sformatf("%0d accepted beats never reached dbg", exp_pending));
      read_register(trace_cfg_pkg::csr_addr_count, rd_data);
      assert (rd_data == expected)
         else log_mismatch($sformatf("beat count %0d, expected %0d", rd_data, expected));
   endtask

   initial begin
      logic [31:0] rd_data;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      repeat (4) @(negedge clk);
      read_register(trace_cfg_pkg::csr_addr_status, rd_data);
      assert (rd_data == 32'(trace_bus_pkg::capt_idle))
         else log_mismatch($sformatf("status %0d after reset, expected idle", rd_data));
      run_capture(main_beats, 1'b1);
      run_capture(tail_beats, 1'b0);
      $display("summary: %0d beats accepted, %0d beats checked on dbg, %0d errors",
               n_accepted, n_checked, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
hdl/trace_cfg_pkg.sv
hdl/trace_bus_pkg.sv
hdl/trace_buf_writer.sv
hdl/trace_buf_reader.sv
hdl/storage_arbiter.sv
hdl/capture_sequencer.sv
hdl/capture_csr.sv
hdl/trace_capture_top.sv
dv/storage_model.sv
dv/tb_trace_capture.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the trace capture testbench with Verilator and run it.
# The exit status is nonzero unless the log holds the pass line.

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_trace_capture -f project.f \
   -o sim_trace_capture > build.log 2>&1 \
   && ./obj_dir/sim_trace_capture > sim.log 2>&1 \
   || echo "build or simulation did not complete, see build.log and sim.log"

grep -q "^Test passed$" sim.log 2>/dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
